// File: Bender.yml
package:
  name: char_classifier

sources:
  - files:
      - hw/clf_types_pkg.sv
      - hw/clf_regmap_pkg.sv
      - hw/weight_bank.sv
      - hw/classify_ctrl.sv
      - hw/dense_mac.sv
      - hw/top3_rank.sv
      - hw/char_classifier.sv
  - target: test
    files:
      - tests/classifier_checker.sv
      - tests/tb_char_classifier.sv

// File: flist.f
hw/clf_types_pkg.sv
hw/clf_regmap_pkg.sv
hw/weight_bank.sv
hw/classify_ctrl.sv
hw/dense_mac.sv
hw/top3_rank.sv
hw/char_classifier.sv
tests/classifier_checker.sv
tests/tb_char_classifier.sv

// File: hw/char_classifier.sv
`default_nettype none

module char_classifier (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_wr_req,
    input  clf_regmap_pkg::bank_addr_t  i_wr_addr,
    input  clf_types_pkg::weight_t      i_wr_data,
    output logic                        o_wr_ack,
    input  logic                        i_cls_req,
    input  clf_types_pkg::feature_vec_t i_features,
    output logic                        o_cls_ack,
    output clf_types_pkg::class_idx_t   o_char  [clf_types_pkg::NUM_RANKED],
    output clf_types_pkg::logit_t       o_logit [clf_types_pkg::NUM_RANKED]
);

    logic                      busy;
    clf_types_pkg::class_idx_t rd_class;
    clf_types_pkg::feat_idx_t  rd_feat;
    clf_types_pkg::weight_t    rd_weight;
    clf_types_pkg::weight_t    rd_bias;
    clf_types_pkg::feature_t   feature;
    clf_types_pkg::logit_t     mac_logit;
    logic                      mac_clear;
    logic                      mac_step;
    logic                      bias_add;
    logic                      rank_clear;
    logic                      rank_insert;

    weight_bank u_weight_bank (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_wr_req   (i_wr_req),
        .i_wr_addr  (i_wr_addr),
        .i_wr_data  (i_wr_data),
        .o_wr_ack   (o_wr_ack),
        .i_busy     (busy),
        .i_rd_class (rd_class),
        .i_rd_feat  (rd_feat),
        .o_rd_weight(rd_weight),
        .o_rd_bias  (rd_bias)
    );

    classify_ctrl u_classify_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_cls_req    (i_cls_req),
        .o_cls_ack    (o_cls_ack),
        .i_features   (i_features),
        .o_busy       (busy),
        .o_class      (rd_class),
        .o_feat       (rd_feat),
        .o_feature    (feature),
        .o_mac_clear  (mac_clear),
        .o_mac_step   (mac_step),
        .o_bias_add   (bias_add),
        .o_rank_clear (rank_clear),
        .o_rank_insert(rank_insert)
    );

    dense_mac u_dense_mac (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_clear   (mac_clear),
        .i_step    (mac_step),
        .i_bias_add(bias_add),
        .i_weight  (rd_weight),
        .i_bias    (rd_bias),
        .i_feature (feature),
        .o_logit   (mac_logit)
    );

    // Class index still holds the class of the logit being inserted
    top3_rank u_top3_rank (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_clear (rank_clear),
        .i_insert(rank_insert),
        .i_class (rd_class),
        .i_logit (mac_logit),
        .o_char  (o_char),
        .o_logit (o_logit)
    );

endmodule

`default_nettype wire

// File: hw/classify_ctrl.sv
`default_nettype none

module classify_ctrl (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_cls_req,
    output logic                        o_cls_ack,
    input  clf_types_pkg::feature_vec_t i_features,
    output logic                        o_busy,
    output clf_types_pkg::class_idx_t   o_class,
    output clf_types_pkg::feat_idx_t    o_feat,
    output clf_types_pkg::feature_t     o_feature,
    output logic                        o_mac_clear,
    output logic                        o_mac_step,
    output logic                        o_bias_add,
    output logic                        o_rank_clear,
    output logic                        o_rank_insert
);

    clf_regmap_pkg::ctrl_state_t state;
    clf_types_pkg::class_idx_t   class_cnt;
    clf_types_pkg::feat_idx_t    feat_cnt;

    assign o_busy = (state != clf_regmap_pkg::ST_IDLE);

    // All strobes and read indices leave on flops, one cycle behind the state
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= clf_regmap_pkg::ST_IDLE;
            class_cnt <= '0;
            feat_cnt <= '0;
            o_cls_ack <= 1'b0;
            o_class <= '0;
            o_feat <= '0;
            o_feature <= '0;
            o_mac_clear <= 1'b0;
            o_mac_step <= 1'b0;
            o_bias_add <= 1'b0;
            o_rank_clear <= 1'b0;
            o_rank_insert <= 1'b0;
        end else begin
            o_mac_clear <= 1'b0;
            o_mac_step <= 1'b0;
            o_bias_add <= 1'b0;
            o_rank_clear <= 1'b0;
            o_rank_insert <= 1'b0;

            case (state)
                clf_regmap_pkg::ST_IDLE: begin
                    if (i_cls_req) begin
                        o_mac_clear <= 1'b1;
                        o_rank_clear <= 1'b1;
                        class_cnt <= '0;
                        feat_cnt <= '0;
                        state <= clf_regmap_pkg::ST_MAC;
                    end
                end
                clf_regmap_pkg::ST_MAC: begin
                    o_mac_step <= 1'b1;
                    o_class <= class_cnt;
                    o_feat <= feat_cnt;
                    o_feature <= i_features[feat_cnt*clf_types_pkg::FEATURE_W +:
                                            clf_types_pkg::FEATURE_W];
                    feat_cnt <= feat_cnt + 1'b1;   // Wraps to 0 for the next class
                    if (feat_cnt == clf_types_pkg::NUM_FEATURES - 1) begin
                        state <= clf_regmap_pkg::ST_BIAS;
                    end
                end
                clf_regmap_pkg::ST_BIAS: begin
                    o_bias_add <= 1'b1;
                    state <= clf_regmap_pkg::ST_RANK;
                end
                clf_regmap_pkg::ST_RANK: begin
                    // Insert samples the finished logit while the MAC clears
                    o_rank_insert <= 1'b1;
                    o_mac_clear <= 1'b1;
                    if (class_cnt == clf_types_pkg::NUM_CLASSES - 1) begin
                        state <= clf_regmap_pkg::ST_DONE;
                    end else begin
                        class_cnt <= class_cnt + 1'b1;
                        state <= clf_regmap_pkg::ST_MAC;
                    end
                end
                clf_regmap_pkg::ST_DONE: begin
                    if (o_cls_ack) begin
                        if (!i_cls_req) begin
                            o_cls_ack <= 1'b0;
                            state <= clf_regmap_pkg::ST_IDLE;
                        end
                    end else if (!o_rank_insert) begin
                        o_cls_ack <= 1'b1;          // Last insert has landed
                    end
                end
                default: state <= clf_regmap_pkg::ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/clf_regmap_pkg.sv
`default_nettype none

package clf_regmap_pkg;

    // Per class: NUM_FEATURES weights, then the bias
    localparam int ENTRIES_PER_CLASS = clf_types_pkg::NUM_FEATURES + 1;
    localparam int BIAS_OFFSET = clf_types_pkg::NUM_FEATURES;
    localparam int BANK_DEPTH = ENTRIES_PER_CLASS * clf_types_pkg::NUM_CLASSES;

    typedef logic [$clog2(BANK_DEPTH)-1:0] bank_addr_t;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_MAC,
        ST_BIAS,
        ST_RANK,
        ST_DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hw/clf_types_pkg.sv
`default_nettype none

package clf_types_pkg;

    // Dimensions
    localparam int NUM_FEATURES = 8;
    localparam int NUM_CLASSES = 6;
    localparam int NUM_RANKED = 3;

    // Data widths
    localparam int FEATURE_W = 24;
    localparam int WEIGHT_W = 16;
    localparam int LOGIT_W = 32;
    localparam int CLASS_W = 5;     // Alphabet-sized class number
    localparam int FEAT_IDX_W = $clog2(NUM_FEATURES);

    typedef logic signed [FEATURE_W-1:0] feature_t;
    typedef logic [NUM_FEATURES*FEATURE_W-1:0] feature_vec_t;
    typedef logic signed [WEIGHT_W-1:0] weight_t;
    typedef logic signed [LOGIT_W-1:0] logit_t;
    typedef logic [CLASS_W-1:0] class_idx_t;
    typedef logic [FEAT_IDX_W-1:0] feat_idx_t;

    // Empty ranking slot
    localparam logit_t LOGIT_MIN = {1'b1, {(LOGIT_W-1){1'b0}}};
    localparam class_idx_t CHAR_NONE = '1;

endpackage

`default_nettype wire

// File: hw/dense_mac.sv
`default_nettype none

module dense_mac (
    input  logic                    i_clk,
    input  logic                    i_rst_n,
    input  logic                    i_clear,
    input  logic                    i_step,
    input  logic                    i_bias_add,
    input  clf_types_pkg::weight_t  i_weight,
    input  clf_types_pkg::weight_t  i_bias,
    input  clf_types_pkg::feature_t i_feature,
    output clf_types_pkg::logit_t   o_logit
);

    localparam int PROD_W = clf_types_pkg::WEIGHT_W + clf_types_pkg::FEATURE_W;

    logic signed [PROD_W-1:0] product;
    clf_types_pkg::logit_t    term;
    clf_types_pkg::logit_t    bias_ext;

    // Full-width signed product, then keep the low 32 bits
    assign product = i_weight * i_feature;
    assign term = clf_types_pkg::logit_t'(product);

    assign bias_ext = clf_types_pkg::logit_t'(i_bias);  // Sign extended

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_logit <= '0;
        end else if (i_clear) begin
            o_logit <= '0;
        end else if (i_step) begin
            o_logit <= o_logit + term;
        end else if (i_bias_add) begin
            o_logit <= o_logit + bias_ext;
        end
    end

endmodule

`default_nettype wire

// File: hw/top3_rank.sv
`default_nettype none

module top3_rank (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_clear,
    input  logic                      i_insert,
    input  clf_types_pkg::class_idx_t i_class,
    input  clf_types_pkg::logit_t     i_logit,
    output clf_types_pkg::class_idx_t o_char  [clf_types_pkg::NUM_RANKED],
    output clf_types_pkg::logit_t     o_logit [clf_types_pkg::NUM_RANKED]
);

    logic [clf_types_pkg::NUM_RANKED-1:0] beats;
    clf_types_pkg::class_idx_t            next_char  [clf_types_pkg::NUM_RANKED];
    clf_types_pkg::logit_t                next_logit [clf_types_pkg::NUM_RANKED];

    // Slots are descending, so beats is set from the insert point downwards
    always_comb begin
        for (int i = 0; i < clf_types_pkg::NUM_RANKED; i++) begin
            beats[i] = (i_logit > o_logit[i]);     // Strict, ties keep the older class
        end

        next_char[0] = beats[0] ? i_class : o_char[0];
        next_logit[0] = beats[0] ? i_logit : o_logit[0];

        for (int i = 1; i < clf_types_pkg::NUM_RANKED; i++) begin
            if (beats[i-1]) begin
                next_char[i] = o_char[i-1];        // Shift down
                next_logit[i] = o_logit[i-1];
            end else if (beats[i]) begin
                next_char[i] = i_class;
                next_logit[i] = i_logit;
            end else begin
                next_char[i] = o_char[i];
                next_logit[i] = o_logit[i];
            end
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < clf_types_pkg::NUM_RANKED; i++) begin
                o_char[i] <= clf_types_pkg::CHAR_NONE;
                o_logit[i] <= clf_types_pkg::LOGIT_MIN;
            end
        end else if (i_clear) begin
            for (int i = 0; i < clf_types_pkg::NUM_RANKED; i++) begin
                o_char[i] <= clf_types_pkg::CHAR_NONE;
                o_logit[i] <= clf_types_pkg::LOGIT_MIN;
            end
        end else if (i_insert) begin
            o_char <= next_char;
            o_logit <= next_logit;
        end
    end

endmodule

`default_nettype wire

// File: hw/weight_bank.sv
`default_nettype none

module weight_bank (
    input  logic                        i_clk,
    input  logic                        i_rst_n,
    input  logic                        i_wr_req,
    input  clf_regmap_pkg::bank_addr_t  i_wr_addr,
    input  clf_types_pkg::weight_t      i_wr_data,
    output logic                        o_wr_ack,
    input  logic                        i_busy,
    input  clf_types_pkg::class_idx_t   i_rd_class,
    input  clf_types_pkg::feat_idx_t    i_rd_feat,
    output clf_types_pkg::weight_t      o_rd_weight,
    output clf_types_pkg::weight_t      o_rd_bias
);

    clf_types_pkg::weight_t     bank [clf_regmap_pkg::BANK_DEPTH];
    clf_regmap_pkg::bank_addr_t rd_base;
    clf_regmap_pkg::bank_addr_t rd_weight_addr;
    clf_regmap_pkg::bank_addr_t rd_bias_addr;
    logic                       wr_accept;

    // First entry of the selected class
    assign rd_base = clf_regmap_pkg::bank_addr_t'(i_rd_class)
                   * clf_regmap_pkg::bank_addr_t'(clf_regmap_pkg::ENTRIES_PER_CLASS);

    assign rd_weight_addr = rd_base + clf_regmap_pkg::bank_addr_t'(i_rd_feat);
    assign rd_bias_addr = rd_base + clf_regmap_pkg::bank_addr_t'(clf_regmap_pkg::BIAS_OFFSET);

    assign o_rd_weight = bank[rd_weight_addr];
    assign o_rd_bias = bank[rd_bias_addr];

    // New request, bank not in use by a run
    assign wr_accept = i_wr_req && !o_wr_ack && !i_busy;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_wr_ack <= 1'b0;
            for (int i = 0; i < clf_regmap_pkg::BANK_DEPTH; i++) begin
                bank[i] <= '0;
            end
        end else begin
            if (wr_accept) begin
                o_wr_ack <= 1'b1;
                if (i_wr_addr < clf_regmap_pkg::BANK_DEPTH) begin
                    bank[i_wr_addr] <= i_wr_data;
                end
                // Out of range addresses are acked and dropped
            end else if (!i_wr_req) begin
                o_wr_ack <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: tests/classifier_checker.sv
`default_nettype none

module classifier_checker (
    input logic i_clk,
    input logic i_rst_n,
    input logic i_wr_req,
    input logic i_wr_ack,
    input logic i_cls_req,
    input logic i_cls_ack,
    input logic i_busy
);

    timeunit 1ns;
    timeprecision 1ps;

    int violations = 0;

    // An ack only answers a pending request
    cls_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_cls_ack) |-> i_cls_req)
        else begin
            violations++;
            $error("classification ack rose without a request");
        end

    wr_ack_needs_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_wr_ack) |-> i_wr_req)
        else begin
            violations++;
            $error("write ack rose without a request");
        end

    cls_four_phase: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $fell(i_cls_ack) |-> !$past(i_cls_req))
        else begin
            violations++;
            $error("classification ack fell while the request was still high");
        end

    // Bank write lands one cycle before its ack
    no_store_while_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        $rose(i_wr_ack) |-> !$past(i_busy))
        else begin
            violations++;
            $error("weight write accepted while a classification was running");
        end

    acks_low_in_reset: assert property (@(posedge i_clk)
        !i_rst_n |-> !i_cls_ack && !i_wr_ack)
        else begin
            violations++;
            $error("ack high during reset");
        end

endmodule

`default_nettype wire

// File: tests/tb_char_classifier.sv
`default_nettype none

module tb_char_classifier;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_OPS = 5 * clf_regmap_pkg::BANK_DEPTH + 20;  // Bank loads plus runs
    localparam int WATCHDOG_CYCLES = 200 * NUM_OPS;
    localparam int FILL_RANDOM = 0;
    localparam int FILL_NEG_BIAS = 1;
    localparam int FILL_TIE = 2;
    localparam int FILL_EXTREME = 3;
    localparam int EPC = clf_regmap_pkg::ENTRIES_PER_CLASS;
    localparam int FW = clf_types_pkg::FEATURE_W;

    localparam clf_types_pkg::weight_t NEG_BIASES [clf_types_pkg::NUM_CLASSES] =
        '{-16'sd500, -16'sd20, -16'sd3000, -16'sd7, -16'sd90, -16'sd1000};
    localparam clf_types_pkg::weight_t TIE_BIASES [clf_types_pkg::NUM_CLASSES] =
        '{16'sd5, 16'sd40, 16'sd2, 16'sd40, 16'sd40, -16'sd3};
    localparam clf_types_pkg::weight_t EXTREME_W [4] =
        '{16'sh8000, 16'sh7fff, 16'shffff, 16'sh0001};

    logic                         clk;
    logic                         rst_n;
    logic                         wr_req;
    clf_regmap_pkg::bank_addr_t   wr_addr;
    clf_types_pkg::weight_t       wr_data;
    logic                         wr_ack;
    logic                         cls_req;
    clf_types_pkg::feature_vec_t  features;
    logic                         cls_ack;
    clf_types_pkg::class_idx_t    dut_char  [clf_types_pkg::NUM_RANKED];
    clf_types_pkg::logit_t        dut_logit [clf_types_pkg::NUM_RANKED];

    clf_types_pkg::weight_t       model_bank [clf_regmap_pkg::BANK_DEPTH];
    clf_types_pkg::weight_t       stage      [clf_regmap_pkg::BANK_DEPTH];
    clf_types_pkg::class_idx_t    exp_char   [clf_types_pkg::NUM_RANKED];
    clf_types_pkg::logit_t        exp_logit  [clf_types_pkg::NUM_RANKED];
    clf_types_pkg::class_idx_t    held_char  [clf_types_pkg::NUM_RANKED];
    clf_types_pkg::logit_t        held_logit [clf_types_pkg::NUM_RANKED];
    clf_types_pkg::feature_vec_t  feats;
    logic [31:0]                  lcg_state = 32'd34;
    logic                         cls_ack_q = 1'b0;
    logic                         wr_ack_q = 1'b0;
    longint                       cycle = 0;
    longint                       cls_ack_cycle = 0;
    longint                       wr_ack_cycle = 0;
    int                           errors = 0;
    int                           checks = 0;
    int                           runs_issued = 0;
    int                           runs_checked = 0;

    char_classifier u_char_classifier (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_wr_req  (wr_req),
        .i_wr_addr (wr_addr),
        .i_wr_data (wr_data),
        .o_wr_ack  (wr_ack),
        .i_cls_req (cls_req),
        .i_features(features),
        .o_cls_ack (cls_ack),
        .o_char    (dut_char),
        .o_logit   (dut_logit)
    );

    bind char_classifier classifier_checker u_classifier_checker (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wr_req (i_wr_req),
        .i_wr_ack (o_wr_ack),
        .i_cls_req(i_cls_req),
        .i_cls_ack(o_cls_ack),
        .i_busy   (busy)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic clf_types_pkg::feature_vec_t random_features();
        clf_types_pkg::feature_vec_t v;
        logic [31:0] r;
        for (int j = 0; j < clf_types_pkg::NUM_FEATURES; j++) begin
            r = lcg_next();
            v[j*FW +: FW] = r[31:8];
        end
        return v;
    endfunction

    // Sum in 64 bits, then keep the low 32 bits
    function automatic clf_types_pkg::logit_t ref_logit(input int cls,
                                                        input clf_types_pkg::feature_vec_t fv);
        longint acc;
        clf_types_pkg::feature_t f;
        acc = 0;
        for (int j = 0; j < clf_types_pkg::NUM_FEATURES; j++) begin
            f = fv[j*FW +: FW];
            acc = acc + longint'(model_bank[cls*EPC + j]) * longint'(f);
        end
        acc = acc + longint'(model_bank[cls*EPC + clf_types_pkg::NUM_FEATURES]);
        return clf_types_pkg::logit_t'(acc);
    endfunction

    function automatic void predict_top3(input clf_types_pkg::feature_vec_t fv);
        clf_types_pkg::logit_t l;
        int pos;
        for (int i = 0; i < clf_types_pkg::NUM_RANKED; i++) begin
            exp_char[i] = '1;
            exp_logit[i] = 32'sh8000_0000;
        end
        for (int c = 0; c < clf_types_pkg::NUM_CLASSES; c++) begin
            l = ref_logit(c, fv);
            pos = clf_types_pkg::NUM_RANKED;
            for (int i = clf_types_pkg::NUM_RANKED - 1; i >= 0; i--) begin
                if (l > exp_logit[i]) pos = i;      // Strictly greater only
            end
            for (int i = clf_types_pkg::NUM_RANKED - 1; i > pos; i--) begin
                exp_char[i] = exp_char[i-1];
                exp_logit[i] = exp_logit[i-1];
            end
            if (pos < clf_types_pkg::NUM_RANKED) begin
                exp_char[pos] = clf_types_pkg::class_idx_t'(c);
                exp_logit[pos] = l;
            end
        end
    endfunction

    function automatic void fill_stage(input int mode);
        logic [31:0] r;
        int c;
        int j;
        for (int a = 0; a < clf_regmap_pkg::BANK_DEPTH; a++) begin
            c = a / EPC;
            j = a % EPC;                    // Last entry of a class is the bias
            r = lcg_next();
            case (mode)
                FILL_RANDOM: stage[a] = r[31:16];
                FILL_NEG_BIAS: stage[a] = (j == EPC - 1) ? NEG_BIASES[c] : '0;
                FILL_TIE: stage[a] = (j == EPC - 1) ? TIE_BIASES[c] : '0;
                default: stage[a] = EXTREME_W[(c + j) % 4];
            endcase
        end
    endfunction

    task automatic check_value(input string name, input longint got, input longint exp);
        checks++;
        assert (got == exp) else begin
            errors++;
            $display("error %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_stable();
        for (int i = 0; i < clf_types_pkg::NUM_RANKED; i++) begin
            check_value($sformatf("o_char[%0d]", i), dut_char[i], held_char[i]);
            check_value($sformatf("o_logit[%0d]", i), dut_logit[i], held_logit[i]);
        end
    endtask

    // Called on a rising edge, returns on the edge where ack is seen low again
    task automatic write_word(input int addr, input clf_types_pkg::weight_t data);
        wr_req <= 1'b1;
        wr_addr <= clf_regmap_pkg::bank_addr_t'(addr);
        wr_data <= data;
        do @(posedge clk); while (!wr_ack);
        if (addr < clf_regmap_pkg::BANK_DEPTH) model_bank[addr] = data;
        wr_req <= 1'b0;
        do @(posedge clk); while (wr_ack);
    endtask

    task automatic load_bank();
        for (int a = 0; a < clf_regmap_pkg::BANK_DEPTH; a++) begin
            write_word(a, stage[a]);
        end
    endtask

    task automatic start_classify(input clf_types_pkg::feature_vec_t fv);
        predict_top3(fv);
        runs_issued++;
        cls_req <= 1'b1;
        features <= fv;
        do @(posedge clk); while (!cls_ack);
    endtask

    task automatic end_classify();
        cls_req <= 1'b0;
        do @(posedge clk); while (cls_ack);
    endtask

    function automatic int total_errors();
        return errors + u_char_classifier.u_classifier_checker.violations;
    endfunction

    // Compare the ranking against the model when ack rises
    always @(posedge clk) begin
        cycle++;
        cls_ack_q <= cls_ack;
        wr_ack_q <= wr_ack;
        if (wr_ack && !wr_ack_q) wr_ack_cycle = cycle;
        if (cls_ack && !cls_ack_q) begin
            cls_ack_cycle = cycle;
            runs_checked++;
            for (int i = 0; i < clf_types_pkg::NUM_RANKED; i++) begin
                check_value($sformatf("o_char[%0d]", i), dut_char[i], exp_char[i]);
                check_value($sformatf("o_logit[%0d]", i), dut_logit[i], exp_logit[i]);
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("checks: %0d, errors: %0d", checks, total_errors());
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        wr_req = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        cls_req = 1'b0;
        features = '0;
        for (int a = 0; a < clf_regmap_pkg::BANK_DEPTH; a++) model_bank[a] = '0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        // Random bank and vectors
        fill_stage(FILL_RANDOM);
        load_bank();
        repeat (5) begin
            start_classify(random_features());
            end_classify();
        end

        // Negative scores must rank
        fill_stage(FILL_NEG_BIAS);
        load_bank();
        start_classify(random_features());
        check_value("o_logit[0]", dut_logit[0], -7);
        check_value("o_logit[1]", dut_logit[1], -20);
        check_value("o_logit[2]", dut_logit[2], -90);
        end_classify();

        // Equal logits keep the lower class first
        fill_stage(FILL_TIE);
        load_bank();
        start_classify(random_features());
        check_value("o_char[0]", dut_char[0], 1);
        check_value("o_char[1]", dut_char[1], 3);
        check_value("o_char[2]", dut_char[2], 4);
        end_classify();

        // Wraparound with extreme operands
        fill_stage(FILL_EXTREME);
        load_bank();
        start_classify({8{24'h800000}});
        end_classify();
        start_classify({4{24'h7fffff, 24'h800000}});
        end_classify();

        // Request held high after ack
        fill_stage(FILL_RANDOM);
        load_bank();
        start_classify(random_features());
        held_char = dut_char;
        held_logit = dut_logit;
        repeat (20) begin
            @(posedge clk);
            check_value("o_cls_ack", longint'(cls_ack), 1);
            check_stable();
        end
        end_classify();
        repeat (10) begin
            @(posedge clk);
            check_value("o_cls_ack", longint'(cls_ack), 0);
            check_stable();
        end
        start_classify(random_features());
        end_classify();

        // Write issued during a run waits for the run to finish
        feats = '0;                         // Logits are the biases alone
        fork
            begin
                start_classify(feats);
                end_classify();
            end
            begin
                repeat (10) @(posedge clk);
                // Largest bias puts class 2 into the ranking
                write_word(2 * EPC + clf_types_pkg::NUM_FEATURES, 16'sh7fff);
            end
        join
        assert (wr_ack_cycle > cls_ack_cycle) else begin
            errors++;
            $display("write was acknowledged before the classification finished");
        end
        start_classify(feats);
        end_classify();

        check_value("classifications compared", runs_checked, runs_issued);
        repeat (2) @(posedge clk);
        $display("checks: %0d, errors: %0d", checks, total_errors());
        if (total_errors() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire
